//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := mc_top_tb
FILELIST  := noc_mem_ctrl.f
BUILD_DIR := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mc_top_tb.sv
`timescale 1ns/1ps

module mc_top_tb;
  import mc_noc_pkg::*;
  import mc_mem_pkg::*;

  localparam int clk_period       = 4;
  localparam int n_trans          = 48;   // upper bound over all tests
  localparam int cycles_per_trans = 40;
  localparam int watchdog_ns =
    (10 + init_delay + bank_words + 10 + n_trans * cycles_per_trans) * clk_period;

  logic      core_ref_clk;
  logic      sys_rst_n;
  noc_flit_u flit_in_data;
  logic      flit_in_val;
  logic      flit_in_rdy;
  noc_flit_u flit_out_data;
  logic      flit_out_val;
  logic      flit_out_rdy;
  logic      ui_rst;
  logic      init_done;

  logic [15:0] lfsr_state;
  int          cyc = 0;                   // index of the last rising edge
  int          tag_cnt;
  mem_data_t   model [256];               // indexed by addr[7:0]
  noc_flit_u   req_q [$];
  noc_flit_u   exp_q [$];
  noc_flit_u   got_q [$];
  int          acc_cyc_q [$];
  int          out_cyc_q [$];
  logic [23:0] addr_q [$];

  mc_top mc_top_inst (
    .core_ref_clk            (core_ref_clk),
    .sys_rst_n               (sys_rst_n),
    .mc_flit_in_data         (flit_in_data),
    .mc_flit_in_val          (flit_in_val),
    .mc_flit_in_rdy          (flit_in_rdy),
    .mc_flit_out_data        (flit_out_data),
    .mc_flit_out_val         (flit_out_val),
    .mc_flit_out_rdy         (flit_out_rdy),
    .mc_ui_clk_sync_rst      (ui_rst),
    .init_calib_complete_out (init_done)
  );

  initial core_ref_clk = 1'b0;
  always #(clk_period / 2) core_ref_clk = ~core_ref_clk;
  always @(posedge core_ref_clk) cyc <= cyc + 1;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_flit(input string name, input noc_flit_u exp, input noc_flit_u act);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic compare_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Error at %0t: %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("Error at %0t: %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};       // one step per bit
    end
    return r;
  endfunction

  function automatic logic [23:0] rand_addr();
    logic [31:0] r;
    r = rand_bits(24);
    return r[23:0];
  endfunction

  task automatic new_batch();
    req_q.delete();
    exp_q.delete();
  endtask

  // builds the request and its expected response from the model
  task automatic add_req(input logic store, input logic [23:0] addr, input mem_data_t data);
    noc_flit_u f;
    noc_flit_u e;
    f.req.tag  = tag_t'(tag_cnt);
    f.req.addr = addr;
    e.rsp.tag  = f.req.tag;
    e.rsp.reserved = '0;
    if (store) begin
      f.req.msg_type = msg_store;
      f.req.data     = data;
      e.rsp.msg_type = msg_store_ack;
      e.rsp.data     = '0;
      model[addr[7:0]] = data;
    end else begin
      f.req.msg_type = msg_load;
      f.req.data     = '0;
      e.rsp.msg_type = msg_load_ack;
      e.rsp.data     = model[addr[7:0]];
    end
    tag_cnt++;
    req_q.push_back(f);
    exp_q.push_back(e);
  endtask

  // all drive and sample points sit 1 ns after a rising edge
  task automatic drive_requests();
    for (int i = 0; i < req_q.size(); i++) begin
      flit_in_data = req_q[i];
      flit_in_val  = 1'b1;
      while (!flit_in_rdy) begin
        @(posedge core_ref_clk);
        #1;
      end
      acc_cyc_q.push_back(cyc + 1);       // taken on the next edge
      @(posedge core_ref_clk);
      #1;
    end
    flit_in_val = 1'b0;
  endtask

  task automatic collect_responses(input int n, input int stall);
    int k;
    k = 0;
    while (got_q.size() < n) begin
      flit_out_rdy = (k >= stall);
      if (flit_out_val && flit_out_rdy) begin
        got_q.push_back(flit_out_data);
        out_cyc_q.push_back(cyc + 1);
      end
      @(posedge core_ref_clk);
      #1;
      k++;
    end
  endtask

  task automatic run_batch(input int stall);
    got_q.delete();
    acc_cyc_q.delete();
    out_cyc_q.delete();
    fork
      drive_requests();
      collect_responses(req_q.size(), stall);
    join
    foreach (exp_q[i]) compare_flit("mc_flit_out_data", exp_q[i], got_q[i]);
    compare_level("mc_flit_out_val", 1'b0, flit_out_val);  // nothing left over
  endtask

  task automatic apply_reset();
    foreach (model[i]) model[i] = '0;
    repeat (10) @(posedge core_ref_clk);
    #1;
    compare_level("mc_ui_clk_sync_rst", 1'b1, ui_rst);
    compare_level("init_calib_complete_out", 1'b0, init_done);
    compare_level("mc_flit_in_rdy", 1'b0, flit_in_rdy);
    compare_level("mc_flit_out_val", 1'b0, flit_out_val);
    sys_rst_n = 1'b1;
  endtask

  task automatic reset_and_init();
    for (int k = 1; k <= init_delay + 1; k++) begin
      @(posedge core_ref_clk);
      #1;
      compare_level("mc_ui_clk_sync_rst", k <= init_delay, ui_rst);
    end
    for (int k = 1; k <= bank_words + 1; k++) begin
      @(posedge core_ref_clk);
      #1;
      compare_level("init_calib_complete_out", k == bank_words + 1, init_done);
      compare_level("mc_flit_in_rdy", k == bank_words + 1, flit_in_rdy);
    end
  endtask

  task automatic zeroed_memory();
    new_batch();
    for (int i = 0; i < 8; i++) add_req(1'b0, rand_addr(), '0);
    run_batch(0);
  endtask

  task automatic store_then_load();
    logic [23:0] a;
    logic [31:0] r;
    new_batch();
    addr_q.delete();
    for (int i = 0; i < 8; i++) begin
      a = rand_addr();
      a[1:0] = 2'(i);                     // every bank twice
      addr_q.push_back(a);
      add_req(1'b1, a, rand_bits(32));
    end
    run_batch(0);
    new_batch();
    foreach (addr_q[i]) begin
      a = addr_q[i];
      r = rand_bits(16);
      a[23:8] = a[23:8] ^ r[15:0];        // alias through upper bits
      add_req(1'b0, a, '0);
    end
    run_batch(0);
  endtask

  task automatic back_to_back_order();
    logic [31:0] r;
    new_batch();
    for (int i = 0; i < 12; i++) begin
      r = rand_bits(1);
      add_req(r[0], rand_addr(), rand_bits(32));
    end
    run_batch(0);
    foreach (acc_cyc_q[i]) compare_count("acceptance cycle", acc_cyc_q[0] + i, acc_cyc_q[i]);
    compare_count("first response cycle", acc_cyc_q[0] + 3, out_cyc_q[0]);
  endtask

  task automatic back_pressure();
    localparam int stall = 20;
    logic [31:0] r;
    int start;
    int stalled;
    new_batch();
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(1);
      add_req(r[0], rand_addr(), rand_bits(32));
    end
    start = cyc;
    run_batch(stall);
    stalled = 0;
    foreach (acc_cyc_q[i]) if (acc_cyc_q[i] <= start + stall + 1) stalled++;
    if (stalled > rsp_fifo_depth || stalled == req_q.size()) begin
      report_failure($sformatf("flit input accepted %0d requests while output stalled", stalled));
    end
  endtask

  initial begin
    #(watchdog_ns);
    report_failure("simulation timed out before all tests finished");
  end

  initial begin
    sys_rst_n    = 1'b0;
    flit_in_data = '0;
    flit_in_val  = 1'b0;
    flit_out_rdy = 1'b1;
    tag_cnt      = 0;
    lfsr_state   = 16'd1569;
    apply_reset();
    reset_and_init();
    zeroed_memory();
    store_then_load();
    back_to_back_order();
    back_pressure();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- noc_mem_ctrl.f
source/mc_noc_pkg.sv
source/mc_mem_pkg.sv
source/mc_bank_if.sv
source/mc_reset_seq.sv
source/mc_req_dispatch.sv
source/mc_mem_bank.sv
source/mc_resp_collect.sv
source/mc_top.sv
dv/mc_top_tb.sv

//--- source/mc_bank_if.sv
`timescale 1ns/1ps

interface mc_bank_req_if;
  import mc_noc_pkg::*;
  import mc_mem_pkg::*;

  logic      valid;   // one-cycle strobe, bank always takes it
  logic      write;
  word_idx_t widx;
  mem_data_t wdata;
  tag_t      tag;
  logic      sweep;   // zeroing in progress, bank stays silent

  modport dispatch (output valid, write, widx, wdata, tag, sweep);
  modport bank     (input valid, write, widx, wdata, tag, sweep);

endinterface

interface mc_bank_rsp_if;
  import mc_noc_pkg::*;

  logic      valid;   // one-cycle strobe
  logic      write;
  mem_data_t rdata;
  tag_t      tag;

  // level from the collector, only carried on the bank 0 instance
  logic      credit_ok;

  modport bank    (output valid, write, rdata, tag);
  modport collect (input valid, write, rdata, tag);

endinterface

//--- source/mc_mem_bank.sv
`timescale 1ns/1ps

module mc_mem_bank (
  input  logic        core_ref_clk,
  input  logic        sys_rst_n,
  mc_bank_req_if.bank req,
  mc_bank_rsp_if.bank rsp
);
  import mc_noc_pkg::*;
  import mc_mem_pkg::*;

  mem_data_t mem [bank_words];
  mem_data_t rdata_q;
  logic      rsp_valid_q;
  logic      rsp_write_q;
  tag_t      rsp_tag_q;

  always_ff @(posedge core_ref_clk) begin
    if (req.valid) begin
      if (req.write) begin
        mem[req.widx] <= req.wdata;
      end else begin
        rdata_q <= mem[req.widx];  // registered read
      end
      rsp_write_q <= req.write;
      rsp_tag_q   <= req.tag;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req.valid & ~req.sweep;  // sweep writes get no ack
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.write = rsp_write_q;
  assign rsp.rdata = rdata_q;
  assign rsp.tag   = rsp_tag_q;

  // zeroing strobes must be writes of zero
  a_sweep_silent : assert property (
    @(posedge core_ref_clk) disable iff (!sys_rst_n)
      (req.valid && req.sweep) |-> (req.write && (req.wdata == '0))
  );

endmodule

//--- source/mc_mem_pkg.sv
package mc_mem_pkg;

  localparam int num_banks     = 4;
  localparam int bank_sel_bits = 2;    // low address bits pick the bank
  localparam int bank_words    = 64;
  localparam int word_idx_bits = 6;    // address bits above the bank select

  typedef logic [bank_sel_bits-1:0] bank_sel_t;
  typedef logic [word_idx_bits-1:0] word_idx_t;

  // cycles the user reset stays up after sys_rst_n releases
  localparam int init_delay = 32;
  typedef logic [$clog2(init_delay+1)-1:0] delay_cnt_t;

  localparam int rsp_fifo_depth = 4;
  localparam int rsp_ptr_bits   = $clog2(rsp_fifo_depth);

  // one spare bit so full and empty differ
  typedef logic [2:0] rsp_cnt_t;

endpackage

//--- source/mc_noc_pkg.sv
package mc_noc_pkg;

  localparam int flit_width = 64;

  // anything other than msg_store on a request is served as a load
  typedef enum logic [1:0] {
    msg_store_ack = 2'd0,
    msg_load      = 2'd1,
    msg_store     = 2'd2,
    msg_load_ack  = 2'd3
  } msg_type_t;

  typedef logic [5:0]  tag_t;       // echoed back in the response
  typedef logic [31:0] mem_data_t;

  typedef struct packed {
    msg_type_t msg_type;
    tag_t      tag;
    logic [23:0] addr;              // upper bits alias
    mem_data_t data;                // store data
  } req_flit_t;

  typedef struct packed {
    msg_type_t msg_type;
    tag_t      tag;
    logic [23:0] reserved;          // always zero
    mem_data_t data;                // load data, zero on store ack
  } rsp_flit_t;

  // same 64-bit flit seen as request or as response
  typedef union packed {
    req_flit_t req;
    rsp_flit_t rsp;
  } noc_flit_u;

endpackage

//--- source/mc_req_dispatch.sv
`timescale 1ns/1ps

module mc_req_dispatch (
  input  logic                  core_ref_clk,
  input  logic                  sys_rst_n,
  input  logic                  ui_rst,
  input  mc_noc_pkg::noc_flit_u flit_in_data,
  input  logic                  flit_in_val,
  output logic                  flit_in_rdy,
  output logic                  init_done,
  mc_bank_req_if.dispatch       bank_req [mc_mem_pkg::num_banks],
  input  logic                  credit_ok
);
  import mc_noc_pkg::*;
  import mc_mem_pkg::*;

  logic      sweep_active;
  word_idx_t sweep_idx;
  req_flit_t req;
  logic      accept;
  logic      iss_valid;     // strobe to the selected bank
  logic      iss_write;
  bank_sel_t iss_bank;
  word_idx_t iss_widx;
  mem_data_t iss_wdata;
  tag_t      iss_tag;

  assign req         = flit_in_data.req;
  assign flit_in_rdy = init_done & credit_ok;
  assign accept      = flit_in_val & flit_in_rdy;

  // zeroing sweep walks one word index per cycle in all banks at once
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n || ui_rst) begin
      sweep_active <= 1'b0;
      sweep_idx    <= '0;
      init_done    <= 1'b0;
    end else if (sweep_active) begin
      if (sweep_idx == word_idx_t'(bank_words - 1)) begin
        sweep_active <= 1'b0;
        init_done    <= 1'b1;  // held until next reset
      end
      sweep_idx <= sweep_idx + 1'b1;
    end else if (!init_done) begin
      sweep_active <= 1'b1;    // first cycle after user reset drops
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= accept;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (accept) begin
      iss_write <= (req.msg_type == msg_store);
      iss_bank  <= req.addr[bank_sel_bits-1:0];
      iss_widx  <= req.addr[bank_sel_bits +: word_idx_bits];
      iss_wdata <= req.data;
      iss_tag   <= req.tag;
    end
  end

  for (genvar b = 0; b < num_banks; b++) begin : g_req
    assign bank_req[b].valid = sweep_active | (iss_valid & (iss_bank == bank_sel_t'(b)));
    assign bank_req[b].write = sweep_active | iss_write;
    assign bank_req[b].widx  = sweep_active ? sweep_idx : iss_widx;
    assign bank_req[b].wdata = sweep_active ? '0 : iss_wdata;
    assign bank_req[b].tag   = sweep_active ? '0 : iss_tag;  // zero tag on sweep
    assign bank_req[b].sweep = sweep_active;
  end

  // an offered flit stays put until it is taken
  a_req_held : assert property (
    @(posedge core_ref_clk) disable iff (!sys_rst_n)
      (flit_in_val && !flit_in_rdy) |=> (flit_in_val && $stable(flit_in_data))
  );

endmodule

//--- source/mc_reset_seq.sv
`timescale 1ns/1ps

module mc_reset_seq (
  input  logic core_ref_clk,
  input  logic sys_rst_n,
  output logic mc_ui_clk_sync_rst
);
  import mc_mem_pkg::*;

  delay_cnt_t delay_cnt;

  // output is registered from the count, so it drops one edge after
  // the count reaches zero
  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      delay_cnt          <= delay_cnt_t'(init_delay);
      mc_ui_clk_sync_rst <= 1'b1;
    end else begin
      if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;  // stops at zero
      end
      mc_ui_clk_sync_rst <= (delay_cnt != '0);
    end
  end

  // user reset must not bounce back up on its own
  a_ui_rst_stays_low : assert property (
    @(posedge core_ref_clk)
      (!mc_ui_clk_sync_rst && sys_rst_n) |=> !mc_ui_clk_sync_rst
  );

endmodule

//--- source/mc_resp_collect.sv
`timescale 1ns/1ps

module mc_resp_collect (
  input  logic                  core_ref_clk,
  input  logic                  sys_rst_n,
  mc_bank_rsp_if.collect        rsp [mc_mem_pkg::num_banks],
  output logic                  credit_ok,
  output mc_noc_pkg::noc_flit_u flit_out_data,
  output logic                  flit_out_val,
  input  logic                  flit_out_rdy
);
  import mc_noc_pkg::*;
  import mc_mem_pkg::*;

  logic [num_banks-1:0] valid_vec;
  logic [num_banks-1:0] write_vec;
  mem_data_t            rdata_vec [num_banks];
  tag_t                 tag_vec [num_banks];
  logic                 sel_valid;
  logic                 sel_write;
  mem_data_t            sel_rdata;
  tag_t                 sel_tag;
  noc_flit_u            push_flit;
  noc_flit_u            fifo_mem [rsp_fifo_depth];
  rsp_cnt_t             wr_ptr;
  rsp_cnt_t             rd_ptr;
  rsp_cnt_t             occupancy;
  rsp_cnt_t             in_flight;
  logic                 pop;

  for (genvar b = 0; b < num_banks; b++) begin : g_rsp
    assign valid_vec[b] = rsp[b].valid;
    assign write_vec[b] = rsp[b].write;
    assign rdata_vec[b] = rsp[b].rdata;
    assign tag_vec[b]   = rsp[b].tag;
  end

  // at most one bank answers per cycle since dispatch issues one request
  always_comb begin
    sel_write = 1'b0;
    sel_rdata = '0;
    sel_tag   = '0;
    for (int b = 0; b < num_banks; b++) begin
      if (valid_vec[b]) begin
        sel_write = write_vec[b];
        sel_rdata = rdata_vec[b];
        sel_tag   = tag_vec[b];
      end
    end
  end

  assign sel_valid     = |valid_vec;
  assign push_flit.rsp = '{msg_type: (sel_write ? msg_store_ack : msg_load_ack),
                           tag:      sel_tag,
                           reserved: '0,
                           data:     (sel_write ? '0 : sel_rdata)};

  // pointers carry one extra bit so their difference is the fill level
  assign occupancy     = wr_ptr - rd_ptr;
  assign flit_out_val  = (occupancy != '0);
  assign flit_out_data = fifo_mem[rd_ptr[rsp_ptr_bits-1:0]];
  assign pop           = flit_out_val & flit_out_rdy;

  // bank stage plus one slot kept for the dispatch issue register
  assign in_flight = rsp_cnt_t'(sel_valid) + rsp_cnt_t'(1);
  assign credit_ok = (occupancy + in_flight) < rsp_cnt_t'(rsp_fifo_depth);

  always_ff @(posedge core_ref_clk) begin
    if (sel_valid) begin
      fifo_mem[wr_ptr[rsp_ptr_bits-1:0]] <= push_flit;
    end
  end

  always_ff @(posedge core_ref_clk) begin
    if (!sys_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (sel_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop)       rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_rsp_onehot : assert property (
    @(posedge core_ref_clk) disable iff (!sys_rst_n) $onehot0(valid_vec)
  );

  // credit scheme has to hold back dispatch early enough
  a_fifo_no_overflow : assert property (
    @(posedge core_ref_clk) disable iff (!sys_rst_n)
      (sel_valid && !pop) |-> (occupancy < rsp_cnt_t'(rsp_fifo_depth))
  );

endmodule

//--- source/mc_top.sv
`timescale 1ns/1ps

module mc_top (
  input  logic                              core_ref_clk,
  input  logic                              sys_rst_n,
  input  logic [mc_noc_pkg::flit_width-1:0] mc_flit_in_data,
  input  logic                              mc_flit_in_val,
  output logic                              mc_flit_in_rdy,
  output logic [mc_noc_pkg::flit_width-1:0] mc_flit_out_data,
  output logic                              mc_flit_out_val,
  input  logic                              mc_flit_out_rdy,
  output logic                              mc_ui_clk_sync_rst,
  output logic                              init_calib_complete_out
);
  import mc_mem_pkg::*;

  mc_bank_req_if bank_req_if [num_banks] ();
  mc_bank_rsp_if bank_rsp_if [num_banks] ();

  mc_reset_seq mc_reset_seq_inst (
    .core_ref_clk       (core_ref_clk),
    .sys_rst_n          (sys_rst_n),
    .mc_ui_clk_sync_rst (mc_ui_clk_sync_rst)
  );

  mc_req_dispatch mc_req_dispatch_inst (
    .core_ref_clk (core_ref_clk),
    .sys_rst_n    (sys_rst_n),
    .ui_rst       (mc_ui_clk_sync_rst),
    .flit_in_data (mc_flit_in_data),
    .flit_in_val  (mc_flit_in_val),
    .flit_in_rdy  (mc_flit_in_rdy),
    .init_done    (init_calib_complete_out),
    .bank_req     (bank_req_if),
    .credit_ok    (bank_rsp_if[0].credit_ok)  // from the collector
  );

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    mc_mem_bank mc_mem_bank_inst (
      .core_ref_clk (core_ref_clk),
      .sys_rst_n    (sys_rst_n),
      .req          (bank_req_if[b]),
      .rsp          (bank_rsp_if[b])
    );
  end

  mc_resp_collect mc_resp_collect_inst (
    .core_ref_clk  (core_ref_clk),
    .sys_rst_n     (sys_rst_n),
    .rsp           (bank_rsp_if),
    .credit_ok     (bank_rsp_if[0].credit_ok),
    .flit_out_data (mc_flit_out_data),
    .flit_out_val  (mc_flit_out_val),
    .flit_out_rdy  (mc_flit_out_rdy)
  );

endmodule
